// ==== Bender.yml ====
package:
  name: fp_vec_misc

sources:
  # Package first, then the units, then the top level
  - hw/fp_vec_pkg.sv
  - hw/vec_shuffle_unit.sv
  - hw/vec_sign_inject_unit.sv
  - hw/vec_result_stage.sv
  - hw/fp_vec_misc_top.sv

  # Testbench
  - target: test
    files:
      - tests/tb_fp_vec_misc.sv

# Simulation top is tb_fp_vec_misc, design top is fp_vec_misc_top

// ==== files.f ====
hw/fp_vec_pkg.sv
hw/vec_shuffle_unit.sv
hw/vec_sign_inject_unit.sv
hw/vec_result_stage.sv
hw/fp_vec_misc_top.sv
tests/tb_fp_vec_misc.sv

// ==== hw/fp_vec_misc_top.sv ====
`timescale 1ns/10ps

module fp_vec_misc_top #(
  parameter int unsigned FLEN = 64
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  // Request
  input  logic [2:0][FLEN-1:0]             operands_i,
  input  fp_vec_pkg::vec_op_e              op_i,
  input  logic                             op_mod_i,
  input  fp_vec_pkg::fp_format_e           src_fmt_i,
  input  logic [fp_vec_pkg::TAG_WIDTH-1:0] tag_i,
  input  logic                             in_valid_i,
  output logic                             in_ready_o,
  // Response
  output logic [FLEN-1:0]                  result_o,
  output logic [fp_vec_pkg::TAG_WIDTH-1:0] tag_o,
  output logic                             out_valid_o,
  input  logic                             out_ready_i
);

  logic [FLEN-1:0] shuffle_result;
  logic [FLEN-1:0] sgnj_result;

  // Both units see every request and the result stage picks one
  vec_shuffle_unit #(
    .FLEN (FLEN)
  ) u_shuffle (
    .operands_i (operands_i),
    .op_mod_i   (op_mod_i),
    .src_fmt_i  (src_fmt_i),
    .result_o   (shuffle_result)
  );

  vec_sign_inject_unit #(
    .FLEN (FLEN)
  ) u_sign_inject (
    .operands_i (operands_i),
    .op_i       (op_i),
    .src_fmt_i  (src_fmt_i),
    .result_o   (sgnj_result)
  );

  vec_result_stage #(
    .FLEN (FLEN)
  ) u_result_stage (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .op_i             (op_i),
    .shuffle_result_i (shuffle_result),
    .sgnj_result_i    (sgnj_result),
    .tag_i            (tag_i),
    .in_valid_i       (in_valid_i),
    .in_ready_o       (in_ready_o),
    .result_o         (result_o),
    .tag_o            (tag_o),
    .out_valid_o      (out_valid_o),
    .out_ready_i      (out_ready_i)
  );

endmodule

// ==== hw/fp_vec_pkg.sv ====
package fp_vec_pkg;

  // ----------------------------------------------------------
  // Element formats
  // ----------------------------------------------------------

  // Encoding follows the usual FPU format field
  typedef enum logic [2:0] {
    FP32    = 3'd0,
    FP64    = 3'd1,
    FP16    = 3'd2,
    FP8     = 3'd3,
    FP16ALT = 3'd4,
    FP8ALT  = 3'd5
  } fp_format_e;

  // ----------------------------------------------------------
  // Operations
  // ----------------------------------------------------------

  // Shuffle takes its result from the shuffle unit,
  // all others from the sign injection unit
  typedef enum logic [1:0] {
    OP_SHUFFLE = 2'd0,
    OP_SGNJ    = 2'd1,
    OP_SGNJN   = 2'd2,
    OP_SGNJX   = 2'd3
  } vec_op_e;

  // ----------------------------------------------------------
  // Request tag
  // ----------------------------------------------------------

  // Tag is opaque here and only travels with the result
  localparam int unsigned TAG_WIDTH = 7;

endpackage

// ==== hw/vec_result_stage.sv ====
`timescale 1ns/10ps

module vec_result_stage #(
  parameter int unsigned FLEN = 64
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Unit results and request side
  input  fp_vec_pkg::vec_op_e            op_i,
  input  logic [FLEN-1:0]                shuffle_result_i,
  input  logic [FLEN-1:0]                sgnj_result_i,
  input  logic [fp_vec_pkg::TAG_WIDTH-1:0] tag_i,
  input  logic                           in_valid_i,
  output logic                           in_ready_o,
  // Response side
  output logic [FLEN-1:0]                result_o,
  output logic [fp_vec_pkg::TAG_WIDTH-1:0] tag_o,
  output logic                           out_valid_o,
  input  logic                           out_ready_i
);

  import fp_vec_pkg::*;

  logic [FLEN-1:0] sel_result;
  logic            load;

  // ----------------------------------------------------------
  // Result select
  // ----------------------------------------------------------

  assign sel_result = (op_i == OP_SHUFFLE) ? shuffle_result_i : sgnj_result_i;

  // ----------------------------------------------------------
  // Handshake
  // ----------------------------------------------------------

  // Accept when empty or when the held result leaves this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      // Refill or drain
      out_valid_o <= in_valid_i;
    end
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------

  // Held stable while stalled since load needs in_ready_o
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      result_o <= '0;
      tag_o    <= '0;
    end else if (load) begin
      result_o <= sel_result;
      tag_o    <= tag_i;
    end
  end

endmodule

// ==== hw/vec_shuffle_unit.sv ====
`timescale 1ns/10ps

module vec_shuffle_unit #(
  parameter int unsigned FLEN = 64
) (
  input  logic [2:0][FLEN-1:0]   operands_i,
  input  logic                   op_mod_i,
  input  fp_vec_pkg::fp_format_e src_fmt_i,
  output logic [FLEN-1:0]        result_o
);

  import fp_vec_pkg::*;

  // One control nibble per narrowest lane
  localparam int unsigned NUM_NIBBLES = FLEN / 8;

  // ----------------------------------------------------------
  // Control nibbles from operand 1
  // ----------------------------------------------------------

  logic [NUM_NIBBLES-1:0]      vec_sel;
  logic [NUM_NIBBLES-1:0][2:0] elem_idx;

  for (genvar n = 0; n < NUM_NIBBLES; n++) begin : gen_nibble
    // Top bit picks the source vector
    assign vec_sel[n]  = operands_i[1][4*n+3];
    // Low three bits name the element
    assign elem_idx[n] = operands_i[1][4*n +: 3];
  end

  // ----------------------------------------------------------
  // Element selection per lane width
  // ----------------------------------------------------------

  // Slot w holds the result for lanes of 32 >> w bits
  logic [2:0][FLEN-1:0] width_result;

  for (genvar w = 0; w < 3; w++) begin : gen_width
    localparam int unsigned LANE_W    = 32 >> w;
    localparam int unsigned NUM_LANES = FLEN / LANE_W;

    if (NUM_LANES > 1) begin : gen_lanes
      localparam int unsigned IDX_W = $clog2(NUM_LANES);

      logic [NUM_LANES-1:0][LANE_W-1:0] src0_lanes;
      logic [NUM_LANES-1:0][LANE_W-1:0] src2_lanes;
      logic [NUM_LANES-1:0][LANE_W-1:0] res_lanes;

      // Lane views over the source vectors
      assign src0_lanes = operands_i[0];
      assign src2_lanes = operands_i[2];

      for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
        logic [IDX_W-1:0] idx;
        logic             from_src2;

        // Upper index bits dropped, so the index wraps at the lane count
        assign idx       = elem_idx[i][IDX_W-1:0];
        assign from_src2 = vec_sel[i] & op_mod_i;

        assign res_lanes[i] = from_src2 ? src2_lanes[idx] : src0_lanes[idx];
      end

      assign width_result[w] = res_lanes;
    end else begin : gen_no_lanes
      // A single full-width lane has nothing to shuffle
      assign width_result[w] = '0;
    end
  end

  // ----------------------------------------------------------
  // Format select
  // ----------------------------------------------------------

  always_comb begin
    result_o = '0;
    case (src_fmt_i)
      FP32: begin
        result_o = width_result[0];
      end
      FP16,
      FP16ALT: begin
        result_o = width_result[1];
      end
      FP8,
      FP8ALT: begin
        result_o = width_result[2];
      end
      default: begin
        // FP64 and unused codes
        result_o = '0;
      end
    endcase
  end

endmodule

// ==== hw/vec_sign_inject_unit.sv ====
`timescale 1ns/10ps

module vec_sign_inject_unit #(
  parameter int unsigned FLEN = 64
) (
  input  logic [2:0][FLEN-1:0]   operands_i,
  input  fp_vec_pkg::vec_op_e    op_i,
  input  fp_vec_pkg::fp_format_e src_fmt_i,
  output logic [FLEN-1:0]        result_o
);

  import fp_vec_pkg::*;

  // New sign of one lane from the two source signs
  function automatic logic new_sign(vec_op_e op, logic sign_a, logic sign_b);
    logic sign;
    case (op)
      OP_SGNJN: sign = ~sign_b;
      OP_SGNJX: sign = sign_a ^ sign_b;
      // SGNJ and the shuffle code whose result is taken elsewhere
      default:  sign = sign_b;
    endcase
    return sign;
  endfunction

  // ----------------------------------------------------------
  // Sign injection per lane width
  // ----------------------------------------------------------

  // Slot w holds the result for lanes of 32 >> w bits
  logic [2:0][FLEN-1:0] width_result;

  for (genvar w = 0; w < 3; w++) begin : gen_width
    localparam int unsigned LANE_W    = 32 >> w;
    localparam int unsigned NUM_LANES = FLEN / LANE_W;

    logic [NUM_LANES-1:0][LANE_W-1:0] op_a_lanes;
    logic [NUM_LANES-1:0][LANE_W-1:0] op_b_lanes;
    logic [NUM_LANES-1:0][LANE_W-1:0] res_lanes;

    assign op_a_lanes = operands_i[0];
    assign op_b_lanes = operands_i[1];

    for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lane
      // Magnitude always from operand 0
      assign res_lanes[i] = {new_sign(op_i, op_a_lanes[i][LANE_W-1], op_b_lanes[i][LANE_W-1]),
                             op_a_lanes[i][LANE_W-2:0]};
    end

    assign width_result[w] = res_lanes;
  end

  // ----------------------------------------------------------
  // Format select
  // ----------------------------------------------------------

  always_comb begin
    result_o = '0;
    case (src_fmt_i)
      FP32:          result_o = width_result[0];
      FP16, FP16ALT: result_o = width_result[1];
      FP8, FP8ALT:   result_o = width_result[2];
      // No FP64 lanes in this group
      FP64:          result_o = '0;
      default:       result_o = '0;
    endcase
  end

endmodule

// ==== tests/tb_fp_vec_misc.sv ====
`timescale 1ns/10ps

module tb_fp_vec_misc;

  import fp_vec_pkg::*;

  localparam int unsigned FLEN           = 64;
  localparam int          NUM_REQ        = 400;
  localparam int          NUM_NO_STALL   = 50;
  localparam int          TIMEOUT_CYCLES = NUM_REQ * 8 + 50;

  logic                       clk_i;
  logic                       rst_n_i;
  logic [2:0][FLEN-1:0]       operands_i;
  vec_op_e                    op_i;
  logic                       op_mod_i;
  fp_format_e                 src_fmt_i;
  logic [TAG_WIDTH-1:0]       tag_i;
  logic                       in_valid_i;
  logic                       in_ready_o;
  logic [FLEN-1:0]            result_o;
  logic [TAG_WIDTH-1:0]       tag_o;
  logic                       out_valid_o;
  logic                       out_ready_i;

  // Scoreboard and monitor state
  logic [FLEN-1:0]      exp_results[$];
  logic [TAG_WIDTH-1:0] exp_tags[$];
  logic                 exp_valid = 1'b0;
  logic                 stalled = 1'b0;
  logic [FLEN-1:0]      held_result;
  logic [TAG_WIDTH-1:0] held_tag;
  int                   received = 0;
  int                   cycle_count = 0;
  logic [63:0]          rng_state = 64'd86;

  fp_vec_misc_top #(
    .FLEN (FLEN)
  ) u_fp_vec_misc_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .operands_i  (operands_i),
    .op_i        (op_i),
    .op_mod_i    (op_mod_i),
    .src_fmt_i   (src_fmt_i),
    .tag_i       (tag_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .result_o    (result_o),
    .tag_o       (tag_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  function automatic logic [63:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // Expected result built lane by lane from the operation rules
  function automatic logic [FLEN-1:0] expected_result(vec_op_e op, logic mod, fp_format_e fmt,
                                                      logic [FLEN-1:0] a, logic [FLEN-1:0] b,
                                                      logic [FLEN-1:0] c);
    int unsigned     lw;
    int unsigned     lanes;
    int unsigned     idx;
    logic [3:0]      nib;
    logic [FLEN-1:0] mask;
    logic [FLEN-1:0] elem;
    logic [FLEN-1:0] res;
    logic            sa;
    logic            sb;
    logic            sign;
    case (fmt)
      FP32:          lw = 32;
      FP16, FP16ALT: lw = 16;
      FP8, FP8ALT:   lw = 8;
      default:       lw = 0;
    endcase
    res = '0;
    if (lw == 0) begin
      return res;
    end
    lanes = FLEN / lw;
    mask  = '1;
    mask  = mask >> (FLEN - lw);
    for (int i = 0; i < lanes; i++) begin
      if (op == OP_SHUFFLE) begin
        nib  = b[4*i +: 4];
        idx  = nib[2:0] % lanes;
        elem = ((nib[3] && mod) ? c : a) >> (idx * lw);
        elem = elem & mask;
      end else begin
        sa = a[i*lw + lw - 1];
        sb = b[i*lw + lw - 1];
        case (op)
          OP_SGNJ:  sign = sb;
          OP_SGNJN: sign = ~sb;
          default:  sign = sa ^ sb;
        endcase
        elem = (a >> (i * lw)) & (mask >> 1);
        elem[lw-1] = sign;
      end
      res = res | (elem << (i * lw));
    end
    return res;
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_result(string name, logic [FLEN-1:0] exp, logic [FLEN-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_tag(string name, logic [TAG_WIDTH-1:0] exp, logic [TAG_WIDTH-1:0] act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      fail_run($sformatf("Mismatch %s: expected 0x%h, actual 0x%h", name, exp, act));
    end
  endtask

  // New random request on the input side
  task automatic drive_request();
    logic [63:0] rnd;
    operands_i <= {next_random(), next_random(), next_random()};
    rnd = next_random();
    op_i     <= vec_op_e'(rnd[1:0]);
    op_mod_i <= rnd[2];
    tag_i    <= rnd[14:8];
    case (rnd[7:4])
      4'd0, 4'd1, 4'd2:    src_fmt_i <= FP32;
      4'd3, 4'd4, 4'd5:    src_fmt_i <= FP16;
      4'd6, 4'd7, 4'd8:    src_fmt_i <= FP16ALT;
      4'd9, 4'd10, 4'd11:  src_fmt_i <= FP8;
      4'd12, 4'd13, 4'd14: src_fmt_i <= FP8ALT;
      default:             src_fmt_i <= FP64;
    endcase
  endtask

  // ----------------------------------------------------------
  // Clock and timeout
  // ----------------------------------------------------------

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles with %0d of %0d results received",
                         cycle_count, received, NUM_REQ));
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  initial begin
    int   sent;
    logic accepted;
    sent        = 0;
    accepted    = 1'b0;
    rst_n_i     = 1'b0;
    operands_i  = '0;
    op_i        = OP_SHUFFLE;
    op_mod_i    = 1'b0;
    src_fmt_i   = FP32;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;

    while (sent < NUM_REQ) begin
      @(posedge clk_i);
      // Full throughput first and then gaps and stalls
      if (sent < NUM_NO_STALL) begin
        out_ready_i <= 1'b1;
      end else begin
        out_ready_i <= (next_random() % 4) != 0;
      end
      // A pending request holds until it is taken
      if (!in_valid_i || accepted) begin
        if (sent < NUM_NO_STALL || (next_random() % 4) != 0) begin
          drive_request();
          in_valid_i <= 1'b1;
        end else begin
          in_valid_i <= 1'b0;
        end
      end
      @(negedge clk_i);
      accepted = in_valid_i && in_ready_o;
      if (accepted) begin
        sent++;
      end
    end

    @(posedge clk_i);
    in_valid_i  <= 1'b0;
    out_ready_i <= 1'b1;
    while (received < NUM_REQ) begin
      @(posedge clk_i);
    end
    repeat (2) @(posedge clk_i);
    $display("*** TEST PASSED ***");
    $finish;
  end

  // ----------------------------------------------------------
  // Monitor and compare
  // ----------------------------------------------------------

  // Sampled mid-cycle where inputs and outputs are settled
  always @(negedge clk_i) begin
    check_flag("out_valid_o", exp_valid, out_valid_o);
    check_flag("in_ready_o", !exp_valid || out_ready_i, in_ready_o);
    if (stalled) begin
      check_result("result_o (held)", held_result, result_o);
      check_tag("tag_o (held)", held_tag, tag_o);
    end
    if (out_valid_o && out_ready_i) begin
      if (exp_results.size() == 0) begin
        fail_run("Output transfer seen while no request was outstanding");
      end else begin
        check_result("result_o", exp_results.pop_front(), result_o);
        check_tag("tag_o", exp_tags.pop_front(), tag_o);
        received++;
      end
    end
    stalled     = out_valid_o && !out_ready_i;
    held_result = result_o;
    held_tag    = tag_o;
    if (in_valid_i && in_ready_o) begin
      exp_results.push_back(expected_result(op_i, op_mod_i, src_fmt_i, operands_i[0],
                                            operands_i[1], operands_i[2]));
      exp_tags.push_back(tag_i);
    end
    // Register refills or drains at the next edge when ready
    if (rst_n_i && (!exp_valid || out_ready_i)) begin
      exp_valid = in_valid_i;
    end
  end

endmodule
